//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT   = 200;   // cycles per wait loop
    localparam int HOLD_CYCLES  = 12;
    localparam int SEED         = 90;
    localparam int ROWS         = 13;

    logic        clk;
    logic        reset_n;
    logic        read_m1;
    logic [15:0] address1;
    logic [15:0] data1;
    logic        m1_ready;
    logic [15:0] num_inst;
    logic [15:0] output_port;
    logic        is_halted;

    logic [15:0] mem [256];
    logic [15:0] tbl_inst [ROWS];
    logic [15:0] tbl_exp [ROWS];
    logic        tbl_wwd [ROWS];

    integer seed;
    logic   random_ready;
    int     value_errors;
    int     timeouts;

    cpu_top cpu_top_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .m1_ready    (m1_ready),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // instruction memory, answers 1 ns after the edge
    always @(posedge clk) begin
        logic [31:0] r;
        #1;
        r = $random(seed);
        m1_ready = random_ready ? r[0] : 1'b1;
        data1    = mem[address1[7:0]];
    end

    task automatic set_row(input int idx, input logic [15:0] inst, input logic wwd,
                           input logic [15:0] exp);
        tbl_inst[idx] = inst;
        tbl_wwd[idx]  = wwd;
        tbl_exp[idx]  = exp;
    endtask

    task automatic load_memory;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 16'he000 | 16'(i);   // opcode 14, never decoded
        end
        for (int i = 0; i < ROWS; i++) begin
            mem[i] = tbl_inst[i];
        end
    endtask

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is 0x%04h, expected 0x%04h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic apply_reset;
        @(posedge clk);
        #1 reset_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_value("output_port after reset", output_port, 16'h0000);
        check_value("num_inst after reset", num_inst, 16'h0000);
        check_value("is_halted after reset", {15'b0, is_halted}, 16'h0000);
        check_value("read_m1 after reset", {15'b0, read_m1}, 16'h0001);
        check_value("address1 after reset", address1, 16'h0000);
        @(posedge clk);
        #1 reset_n = 1'b0;
    endtask

    task automatic run_program;
        logic [15:0] prev;
        int cycles;
        for (int i = 0; i < ROWS; i++) begin
            if (tbl_wwd[i]) begin
                prev   = output_port;
                cycles = 0;
                while (output_port === prev && cycles < WAIT_LIMIT) begin
                    @(negedge clk);
                    cycles++;
                end
                if (output_port === prev) begin
                    $display("timeout: output_port never changed for the WWD in row %0d", i);
                    timeouts++;
                end else begin
                    check_value($sformatf("output_port at row %0d", i), output_port, tbl_exp[i]);
                end
            end
        end
        cycles = 0;
        while (is_halted !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (is_halted !== 1'b1) begin
            $display("timeout: is_halted never rose after the last row");
            timeouts++;
        end else begin
            check_value("num_inst at halt", num_inst, 16'(ROWS));
        end
    endtask

    // halted core must stay frozen while fetch backs up
    task automatic check_halt_hold;
        logic [15:0] inst_seen;
        logic [15:0] port_seen;
        int cycles;
        inst_seen = num_inst;
        port_seen = output_port;
        cycles    = 0;
        while (read_m1 !== 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (read_m1 !== 1'b0) begin
            $display("timeout: read_m1 stayed high after the halt");
            timeouts++;
        end
        repeat (HOLD_CYCLES) @(negedge clk);
        check_value("num_inst after halt", num_inst, inst_seen);
        check_value("output_port after halt", output_port, port_seen);
        check_value("is_halted after halt", {15'b0, is_halted}, 16'h0001);
    endtask

    initial begin
        clk          = 1'b0;
        reset_n      = 1'b1;
        data1        = '0;
        m1_ready     = 1'b0;
        random_ready = 1'b0;
        seed         = SEED;
        value_errors = 0;
        timeouts     = 0;

        // rs 11:10, rt 9:8, rd 7:6
        set_row(0,  16'h6112, 1'b0, 16'h0000);   // lhi r1, 0x12
        set_row(1,  16'h4534, 1'b0, 16'h0000);   // adi r1, r1, 0x34
        set_row(2,  16'hf41c, 1'b1, 16'h1234);   // wwd r1
        set_row(3,  16'h42fd, 1'b0, 16'h0000);   // adi r2, r0, -3
        set_row(4,  16'hf81c, 1'b1, 16'hfffd);   // wwd r2
        set_row(5,  16'hf6c0, 1'b0, 16'h0000);   // add r3, r1, r2
        set_row(6,  16'hfc1c, 1'b1, 16'h1231);   // wwd r3
        set_row(7,  16'hf701, 1'b0, 16'h0000);   // sub r0, r1, r3
        set_row(8,  16'hf01c, 1'b1, 16'h0003);   // wwd r0
        set_row(9,  16'h407f, 1'b0, 16'h0000);   // adi r0, r0, 0x7f
        set_row(10, 16'hf181, 1'b0, 16'h0000);   // sub r2, r0, r1
        set_row(11, 16'hf81c, 1'b1, 16'hee4e);   // wwd r2
        set_row(12, 16'hf01d, 1'b0, 16'h0000);   // hlt
        load_memory();

        // first pass, memory always ready
        apply_reset();
        run_program();
        check_halt_hold();

        // second pass after a fresh reset, with wait states
        random_ready = 1'b1;
        apply_reset();
        run_program();
        check_halt_hold();

        $display("checks done: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/inst_queue_if.sv
rtl/fetch_unit.sv
rtl/inst_queue.sv
rtl/exec_unit.sv
rtl/cpu_top.sv
bench/cpu_tb.sv

//--- rtl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath sizes
`define WORD_WIDTH      16
`define REG_COUNT       4
`define REG_ADDR_WIDTH  2
`define IMM_WIDTH       8

// fetch buffering
`define QUEUE_DEPTH     4

`endif

//--- rtl/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_idx_t;

    // bits 15:12 of the instruction
    typedef enum logic [3:0] {
        OP_ADI   = 4'd4,
        OP_LHI   = 4'd6,
        OP_RTYPE = 4'd15
    } opcode_t;

    // bits 5:0, only meaningful for r-type
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funct_t;

    ////////////////////
    // one fetched word, tagged with its address
    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_item_t;

endpackage

`default_nettype wire

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic           clk,
    input  logic           reset_n,
    // instruction memory, port 1
    output logic           read_m1,
    output cpu_pkg::word_t address1,
    input  cpu_pkg::word_t data1,
    input  logic           m1_ready,
    // status
    output cpu_pkg::word_t num_inst,
    output cpu_pkg::word_t output_port,
    output logic           is_halted
);

    inst_queue_if #(
        .item_t(cpu_pkg::fetch_item_t)
    ) iq_if ();

    ////////////////////
    // producer
    fetch_unit fetch_unit_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .read_m1  (read_m1),
        .address1 (address1),
        .data1    (data1),
        .m1_ready (m1_ready),
        .q        (iq_if.producer)
    );

    ////////////////////
    // buffer
    inst_queue #(
        .item_t(cpu_pkg::fetch_item_t)
    ) inst_queue_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .q       (iq_if.buffer)
    );

    ////////////////////
    // consumer
    exec_unit exec_unit_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .q           (iq_if.consumer),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module exec_unit (
    input  logic           clk,
    input  logic           reset_n,
    inst_queue_if.consumer q,
    output cpu_pkg::word_t num_inst,
    output cpu_pkg::word_t output_port,
    output logic           is_halted
);

    localparam int PAD_W = `WORD_WIDTH - `IMM_WIDTH;

    cpu_pkg::word_t    inst;
    cpu_pkg::opcode_t  opcode;
    cpu_pkg::funct_t   funct;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    cpu_pkg::reg_idx_t rd;
    logic [`IMM_WIDTH-1:0] imm;

    cpu_pkg::word_t regs [`REG_COUNT];
    cpu_pkg::word_t rs_val;
    cpu_pkg::word_t rt_val;
    cpu_pkg::word_t imm_sext;

    logic              wr_en;
    cpu_pkg::reg_idx_t wr_idx;
    cpu_pkg::word_t    wr_data;
    logic              is_wwd;
    logic              is_hlt;

    // take the head whenever one is there, until halted
    assign q.pop = !q.empty && !is_halted;

    ////////////////////
    // field split
    assign inst   = q.pop_item.inst;
    assign opcode = cpu_pkg::opcode_t'(inst[15:12]);
    assign rs     = inst[11:10];
    assign rt     = inst[9:8];
    assign rd     = inst[7:6];
    assign funct  = cpu_pkg::funct_t'(inst[5:0]);
    assign imm    = inst[`IMM_WIDTH-1:0];

    assign rs_val   = regs[rs];
    assign rt_val   = regs[rt];
    assign imm_sext = {{PAD_W{imm[`IMM_WIDTH-1]}}, imm};

    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = rd;
        wr_data = rs_val + rt_val;
        is_wwd  = 1'b0;
        is_hlt  = 1'b0;
        case (opcode)
            cpu_pkg::OP_RTYPE: begin
                case (funct)
                    cpu_pkg::FN_ADD: wr_en = 1'b1;
                    cpu_pkg::FN_SUB: begin
                        wr_en   = 1'b1;
                        wr_data = rs_val - rt_val;
                    end
                    cpu_pkg::FN_WWD: is_wwd = 1'b1;
                    cpu_pkg::FN_HLT: is_hlt = 1'b1;
                    default: ;   // retires as a no-op
                endcase
            end
            cpu_pkg::OP_ADI: begin
                wr_en   = 1'b1;
                wr_idx  = rt;
                wr_data = rs_val + imm_sext;
            end
            cpu_pkg::OP_LHI: begin
                wr_en   = 1'b1;
                wr_idx  = rt;
                wr_data = {imm, {PAD_W{1'b0}}};   // upper byte
            end
            default: ;
        endcase
    end

    ////////////////////
    // retire on the pop edge
    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            num_inst    <= '0;
            output_port <= '0;
            is_halted   <= 1'b0;
        end else if (q.pop) begin
            if (wr_en) begin
                regs[wr_idx] <= wr_data;
            end
            if (is_wwd) begin
                output_port <= rs_val;
            end
            if (is_hlt) begin
                is_halted <= 1'b1;
            end
            num_inst <= num_inst + 1'b1;   // hlt counts too
        end
    end

    // once hlt retires the queue is left alone
    a_halt_stops_pop : assert property (
        @(posedge clk) disable iff (reset_n)
        q.pop && is_hlt |=> is_halted && !q.pop
    );

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic           clk,
    input  logic           reset_n,
    output logic           read_m1,
    output cpu_pkg::word_t address1,
    input  cpu_pkg::word_t data1,
    input  logic           m1_ready,
    inst_queue_if.producer q
);

    cpu_pkg::word_t pc;

    // request as long as the queue has a free slot
    assign read_m1  = !q.full;
    assign address1 = pc;

    // a read completes at the edge where ready is seen
    assign q.push      = read_m1 && m1_ready;
    assign q.push_item = '{pc: pc, inst: data1};

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= '0;
        end else if (q.push) begin
            pc <= pc + 1'b1;   // straight-line stream
        end
    end

    ////////////////////
    // checks

    a_no_push_full : assert property (
        @(posedge clk) disable iff (reset_n)
        q.push |-> !q.full
    );

endmodule

`default_nettype wire

//--- rtl/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module inst_queue #(
    parameter type item_t = cpu_pkg::fetch_item_t,
    parameter int  DEPTH  = `QUEUE_DEPTH   // power of two
) (
    input  logic         clk,
    input  logic         reset_n,
    inst_queue_if.buffer q
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

    item_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign q.full     = (count == FULL_COUNT);
    assign q.empty    = (count == '0);
    assign q.pop_item = mem[rd_ptr];

    ////////////////////
    // storage
    always_ff @(posedge clk) begin
        if (q.push) begin
            mem[wr_ptr] <= q.push_item;
        end
    end

    ////////////////////
    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (q.push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
            end
            if (q.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({q.push, q.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    ////////////////////
    // checks

    a_no_push_full : assert property (
        @(posedge clk) disable iff (reset_n)
        q.push |-> !q.full
    );

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (reset_n)
        q.pop |-> !q.empty
    );

    // a push into an empty queue is at the head one cycle later
    a_push_visible : assert property (
        @(posedge clk) disable iff (reset_n)
        q.push && q.empty |=> !q.empty && q.pop_item == $past(q.push_item)
    );

endmodule

`default_nettype wire

//--- rtl/inst_queue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface inst_queue_if #(
    parameter type item_t = cpu_pkg::fetch_item_t
);

    logic  push;       // strobe, fetch side
    item_t push_item;
    logic  full;       // level
    logic  empty;      // level
    item_t pop_item;   // head entry
    logic  pop;        // strobe, execute side

    modport producer (
        output push,
        output push_item,
        input  full
    );

    modport buffer (
        input  push,
        input  push_item,
        input  pop,
        output full,
        output empty,
        output pop_item
    );

    modport consumer (
        output pop,
        input  empty,
        input  pop_item
    );

endinterface

`default_nettype wire
